// ==== hdl/fusePkg.sv ====
`default_nettype none

package fusePkg;

    localparam int numUopsIn = 4;
    localparam int numUopsOut = 3;
    localparam int bufSize = 16;
    // Room for the op parked in the window plus one whole group
    localparam int fullThreshold = numUopsIn + 1;
    localparam int ptrW = $clog2(bufSize);

    typedef logic [4:0] regIdx_t;
    typedef logic [31:0] imm_t;
    typedef logic [31:0] pc_t;
    typedef logic [5:0] branchTag_t;
    typedef logic [ptrW:0] count_t;

    typedef enum logic [1:0] {
        INT,
        LSU,
        MUL
    } fuType_t;

    typedef enum logic [3:0] {
        ADD,
        LUI,
        AUIPC,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        OTHER,
        // addi fused into the following branch
        FADDI_BEQ,
        FADDI_BNE,
        FADDI_BLT,
        FADDI_BGE,
        FADDI_BLTU,
        FADDI_BGEU
    } intOp_t;

    typedef struct packed {
        logic valid;
        pc_t pc;
        fuType_t fu;
        intOp_t opcode;
        regIdx_t rd;
        regIdx_t rs0;
        regIdx_t rs1;
        imm_t imm;
        logic immB;  // second operand is the immediate
        branchTag_t branchTag;
        logic predTaken;
        logic compressed;
    } decodedUop_t;

endpackage

`default_nettype wire

// ==== hdl/queueCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module queueCounter (
    input wire clk,
    input wire rst,
    input wire mispredict,
    input wire fusePkg::count_t wrCount,
    input wire fusePkg::count_t rdCount,
    output logic [fusePkg::ptrW-1:0] wrPtr,
    output logic [fusePkg::ptrW-1:0] rdPtr,
    output fusePkg::count_t used,
    output logic full
);

    fusePkg::count_t usedNext;
    fusePkg::count_t freeNext;

    assign usedNext = used + wrCount - rdCount;
    assign freeNext = fusePkg::count_t'(fusePkg::bufSize) - usedNext;

    // Pointers wrap naturally since the buffer size is a power of two
    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            wrPtr <= '0;
            rdPtr <= '0;
            used <= '0;
            full <= 1'b0;
        end else begin
            wrPtr <= wrPtr + wrCount[fusePkg::ptrW-1:0];
            rdPtr <= rdPtr + rdCount[fusePkg::ptrW-1:0];
            used <= usedNext;
            full <= freeNext < fusePkg::count_t'(fusePkg::fullThreshold);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uopQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module uopQueue (
    input wire clk,
    input wire rst,
    input wire mispredict,
    input wire outEn,
    input wire full,
    input wire fusePkg::decodedUop_t insUops [fusePkg::numUopsIn],
    input wire [fusePkg::ptrW-1:0] wrPtr,
    input wire [fusePkg::ptrW-1:0] rdPtr,
    input wire fusePkg::count_t used,
    output fusePkg::count_t wrCount,
    output fusePkg::count_t rdCount,
    output fusePkg::decodedUop_t uopOut [fusePkg::numUopsOut]
);

    fusePkg::decodedUop_t buffer [fusePkg::bufSize];
    logic [fusePkg::ptrW-1:0] slotOff [fusePkg::numUopsIn];
    fusePkg::count_t insCount;
    logic writeEn;
    logic readEn;

    assign writeEn = !full && !mispredict;
    assign readEn = outEn && !mispredict;

    // Slot offset of each insert op is the number of valid ops below it
    always_comb begin
        fusePkg::count_t cnt;
        cnt = '0;
        for (int i = 0; i < fusePkg::numUopsIn; i++) begin
            slotOff[i] = cnt[fusePkg::ptrW-1:0];
            if (insUops[i].valid) begin
                cnt = cnt + 1'b1;
            end
        end
        insCount = cnt;
    end

    assign wrCount = writeEn ? insCount : '0;

    always_comb begin
        rdCount = '0;
        if (readEn) begin
            if (used < fusePkg::count_t'(fusePkg::numUopsOut)) begin
                rdCount = used;
            end else begin
                rdCount = fusePkg::count_t'(fusePkg::numUopsOut);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeEn) begin
            for (int i = 0; i < fusePkg::numUopsIn; i++) begin
                if (insUops[i].valid) begin
                    buffer[wrPtr + slotOff[i]] <= insUops[i];
                end
            end
        end
    end

    // Lanes fill from 0; they hold while rename is stalled
    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            for (int l = 0; l < fusePkg::numUopsOut; l++) begin
                uopOut[l].valid <= 1'b0;
            end
        end else if (outEn) begin
            for (int l = 0; l < fusePkg::numUopsOut; l++) begin
                if (fusePkg::count_t'(l) < rdCount) begin
                    uopOut[l] <= buffer[rdPtr + l[fusePkg::ptrW-1:0]];
                end else begin
                    uopOut[l].valid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fusionWindow.sv ====
`timescale 1ns/1ps
`default_nettype none

module fusionWindow (
    input wire clk,
    input wire rst,
    input wire mispredict,
    input wire full,
    input wire fusePkg::decodedUop_t uopIn [fusePkg::numUopsIn],
    output fusePkg::decodedUop_t insUops [fusePkg::numUopsIn]
);

    fusePkg::decodedUop_t uop [fusePkg::numUopsIn];
    fusePkg::decodedUop_t window [fusePkg::numUopsIn+1];
    fusePkg::decodedUop_t fusedUops [fusePkg::numUopsIn];
    fusePkg::decodedUop_t nextUop [fusePkg::numUopsIn];
    logic [fusePkg::numUopsIn:0] consumed;

    function automatic logic isBranch(input fusePkg::intOp_t op);
        return op inside {fusePkg::BEQ, fusePkg::BNE, fusePkg::BLT,
                          fusePkg::BGE, fusePkg::BLTU, fusePkg::BGEU};
    endfunction

    // lui/auipc rd followed by addi rd, rd, imm
    function automatic logic isUpperAddi(
        input fusePkg::decodedUop_t a,
        input fusePkg::decodedUop_t b
    );
        return a.valid && b.valid &&
            a.fu == fusePkg::INT &&
            (a.opcode == fusePkg::LUI || a.opcode == fusePkg::AUIPC) &&
            b.fu == fusePkg::INT && b.opcode == fusePkg::ADD && b.immB &&
            b.rs0 == b.rd && a.rd == b.rd;
    endfunction

    // addi rd, rd, imm followed by a branch comparing rd
    function automatic logic isAddiBranch(
        input fusePkg::decodedUop_t a,
        input fusePkg::decodedUop_t b
    );
        return a.valid && b.valid &&
            a.fu == fusePkg::INT && a.opcode == fusePkg::ADD && a.immB &&
            a.rs0 == a.rd &&
            b.fu == fusePkg::INT && isBranch(b.opcode) &&
            b.rs0 == a.rd;
    endfunction

    function automatic fusePkg::intOp_t fusedBranchOp(input fusePkg::intOp_t op);
        case (op)
            fusePkg::BNE: return fusePkg::FADDI_BNE;
            fusePkg::BLT: return fusePkg::FADDI_BLT;
            fusePkg::BGE: return fusePkg::FADDI_BGE;
            fusePkg::BLTU: return fusePkg::FADDI_BLTU;
            fusePkg::BGEU: return fusePkg::FADDI_BGEU;
            default: return fusePkg::FADDI_BEQ;
        endcase
    endfunction

    // Held group plus the first op of the incoming one
    always_comb begin
        for (int i = 0; i < fusePkg::numUopsIn; i++) begin
            window[i] = uop[i];
        end
        window[fusePkg::numUopsIn] = uopIn[0];
    end

    always_comb begin
        consumed = '0;
        for (int i = 0; i < fusePkg::numUopsIn; i++) begin
            fusedUops[i] = window[i];
        end

        // Left to right, an op already eaten by a pair cannot start another
        for (int i = 0; i < fusePkg::numUopsIn; i++) begin
            if (!consumed[i] && isUpperAddi(window[i], window[i+1])) begin
                fusedUops[i].opcode = fusePkg::ADD;
                fusedUops[i].imm = {window[i].imm[31:12], 12'b0} +
                    {{20{window[i+1].imm[11]}}, window[i+1].imm[11:0]};
                consumed[i+1] = 1'b1;
            end else if (!consumed[i] && isAddiBranch(window[i], window[i+1])) begin
                fusedUops[i].opcode = fusedBranchOp(window[i+1].opcode);
                fusedUops[i].imm = {window[i].imm[11:0], 7'b0, window[i+1].imm[12:0]};
                fusedUops[i].immB = 1'b0;
                // rd stays with the addi, the rest follows the branch
                fusedUops[i].rs0 = window[i+1].rs0;
                fusedUops[i].rs1 = window[i+1].rs1;
                fusedUops[i].pc = window[i+1].pc;
                fusedUops[i].branchTag = window[i+1].branchTag;
                fusedUops[i].predTaken = window[i+1].predTaken;
                fusedUops[i].compressed = window[i+1].compressed;
                consumed[i+1] = 1'b1;
            end
        end

        for (int i = 1; i < fusePkg::numUopsIn; i++) begin
            if (consumed[i]) begin
                fusedUops[i].valid = 1'b0;
            end
        end

        for (int i = 0; i < fusePkg::numUopsIn; i++) begin
            nextUop[i] = uopIn[i];
        end
        // Incoming slot 0 already merged into the last held op
        nextUop[0].valid = uopIn[0].valid && !consumed[fusePkg::numUopsIn];
    end

    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            for (int i = 0; i < fusePkg::numUopsIn; i++) begin
                uop[i].valid <= 1'b0;
                insUops[i].valid <= 1'b0;
            end
        end else if (!full) begin
            uop <= nextUop;
            insUops <= fusedUops;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fuseStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fuseStage (
    input wire clk,
    input wire rst,
    input wire mispredict,
    input wire outEn,
    input wire fusePkg::decodedUop_t uopIn [fusePkg::numUopsIn],
    output logic full,
    output fusePkg::decodedUop_t uopOut [fusePkg::numUopsOut]
);

    fusePkg::decodedUop_t insUops [fusePkg::numUopsIn];
    fusePkg::count_t wrCount;
    fusePkg::count_t rdCount;
    fusePkg::count_t used;
    logic [fusePkg::ptrW-1:0] wrPtr;
    logic [fusePkg::ptrW-1:0] rdPtr;

    fusionWindow i_fusionWindow (
        .clk(clk),
        .rst(rst),
        .mispredict(mispredict),
        .full(full),
        .uopIn(uopIn),
        .insUops(insUops)
    );

    uopQueue i_uopQueue (
        .clk(clk),
        .rst(rst),
        .mispredict(mispredict),
        .outEn(outEn),
        .full(full),
        .insUops(insUops),
        .wrPtr(wrPtr),
        .rdPtr(rdPtr),
        .used(used),
        .wrCount(wrCount),
        .rdCount(rdCount),
        .uopOut(uopOut)
    );

    queueCounter i_queueCounter (
        .clk(clk),
        .rst(rst),
        .mispredict(mispredict),
        .wrCount(wrCount),
        .rdCount(rdCount),
        .wrPtr(wrPtr),
        .rdPtr(rdPtr),
        .used(used),
        .full(full)
    );

endmodule

`default_nettype wire

// ==== dv/fuseRefModel.svh ====
`ifndef FUSE_REF_MODEL_SVH
`define FUSE_REF_MODEL_SVH

// Last accepted group as the window holds it, and ops still owed to rename
fusePkg::decodedUop_t heldGroup [fusePkg::numUopsIn];
fusePkg::decodedUop_t expQ [$];
int upperFused = 0;
int branchFused = 0;

function automatic bit isSelfAddi(input fusePkg::decodedUop_t u);
    return u.valid && u.fu == fusePkg::INT && u.opcode == fusePkg::ADD &&
        u.immB && u.rs0 == u.rd;
endfunction

// OTHER means the op is no branch
function automatic fusePkg::intOp_t fusedCode(input fusePkg::intOp_t op);
    case (op)
        fusePkg::BEQ: return fusePkg::FADDI_BEQ;
        fusePkg::BNE: return fusePkg::FADDI_BNE;
        fusePkg::BLT: return fusePkg::FADDI_BLT;
        fusePkg::BGE: return fusePkg::FADDI_BGE;
        fusePkg::BLTU: return fusePkg::FADDI_BLTU;
        fusePkg::BGEU: return fusePkg::FADDI_BGEU;
        default: return fusePkg::OTHER;
    endcase
endfunction

function automatic bit isUpperPair(input fusePkg::decodedUop_t a, input fusePkg::decodedUop_t b);
    return a.valid && a.fu == fusePkg::INT &&
        (a.opcode == fusePkg::LUI || a.opcode == fusePkg::AUIPC) &&
        isSelfAddi(b) && b.rd == a.rd;
endfunction

function automatic bit isBranchPair(input fusePkg::decodedUop_t a, input fusePkg::decodedUop_t b);
    return isSelfAddi(a) && b.valid && b.fu == fusePkg::INT &&
        fusedCode(b.opcode) != fusePkg::OTHER && b.rs0 == a.rd;
endfunction

function automatic bit heldValid();
    bit found;
    found = 1'b0;
    for (int k = 0; k < fusePkg::numUopsIn; k++) begin
        found = found | heldGroup[k].valid;
    end
    return found;
endfunction

task automatic flushModel();
    for (int k = 0; k < fusePkg::numUopsIn; k++) begin
        heldGroup[k] = '0;
    end
    expQ.delete();
endtask

// Held group plus the new slot 0, scanned pair by pair from the left
task automatic acceptGroup(input fusePkg::decodedUop_t grp [fusePkg::numUopsIn]);
    fusePkg::decodedUop_t win [fusePkg::numUopsIn+1];
    fusePkg::decodedUop_t f;
    int i;
    for (int k = 0; k < fusePkg::numUopsIn; k++) begin
        win[k] = heldGroup[k];
    end
    win[fusePkg::numUopsIn] = grp[0];
    i = 0;
    while (i < fusePkg::numUopsIn) begin
        f = win[i];
        if (isUpperPair(win[i], win[i+1])) begin
            f.opcode = fusePkg::ADD;
            f.imm = (win[i].imm & 32'hFFFF_F000) +
                fusePkg::imm_t'(int'($signed(win[i+1].imm[11:0])));
            expQ.push_back(f);
            upperFused++;
            i += 2;
        end else if (isBranchPair(win[i], win[i+1])) begin
            f.opcode = fusedCode(win[i+1].opcode);
            f.imm = (fusePkg::imm_t'(win[i].imm[11:0]) << 20) |
                fusePkg::imm_t'(win[i+1].imm[12:0]);
            f.immB = 1'b0;
            f.pc = win[i+1].pc;
            f.rs0 = win[i+1].rs0;
            f.rs1 = win[i+1].rs1;
            f.branchTag = win[i+1].branchTag;
            f.predTaken = win[i+1].predTaken;
            f.compressed = win[i+1].compressed;
            expQ.push_back(f);
            branchFused++;
            i += 2;
        end else begin
            if (f.valid) begin
                expQ.push_back(f);
            end
            i++;
        end
    end
    for (int k = 0; k < fusePkg::numUopsIn; k++) begin
        heldGroup[k] = grp[k];
    end
    // Pair reached into the new group
    if (i > fusePkg::numUopsIn) begin
        heldGroup[0].valid = 1'b0;
    end
endtask

`endif

// ==== dv/fuseStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fuseStageTb;

    typedef enum int {
        holdEdge,
        readEdge,
        flushEdge
    } edgeKind_t;

    logic clk = 1'b0;
    logic rst;
    logic mispredict;
    logic outEn;
    logic full;
    fusePkg::decodedUop_t uopIn [fusePkg::numUopsIn];
    fusePkg::decodedUop_t uopOut [fusePkg::numUopsOut];
    fusePkg::decodedUop_t lastOut [fusePkg::numUopsOut];
    edgeKind_t edgeKind = flushEdge;
    string testName = "reset";
    fusePkg::pc_t nextPc = 32'h0000_1000;
    fusePkg::branchTag_t nextTag = '0;

    `include "fuseRefModel.svh"

    always #4 clk = ~clk;

    fuseStage i_fuseStage (
        .clk(clk),
        .rst(rst),
        .mispredict(mispredict),
        .outEn(outEn),
        .uopIn(uopIn),
        .full(full),
        .uopOut(uopOut)
    );

    task automatic failRun(input string msg);
        $display("*** FAILED ***");
        $display("%s", msg);
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkField(input int lane, input string field,
                              input logic [31:0] expVal, input logic [31:0] actVal);
        assert (expVal === actVal) else failRun($sformatf(
            "[ERROR] %s lane %0d %s: expected %h, actual %h",
            testName, lane, field, expVal, actVal));
    endtask

    task automatic compareUop(input int lane, input fusePkg::decodedUop_t e,
                              input fusePkg::decodedUop_t a);
        checkField(lane, "pc", e.pc, a.pc);
        checkField(lane, "fu", 32'(e.fu), 32'(a.fu));
        checkField(lane, "opcode", 32'(e.opcode), 32'(a.opcode));
        checkField(lane, "rd", 32'(e.rd), 32'(a.rd));
        checkField(lane, "rs0", 32'(e.rs0), 32'(a.rs0));
        checkField(lane, "rs1", 32'(e.rs1), 32'(a.rs1));
        checkField(lane, "imm", e.imm, a.imm);
        checkField(lane, "immB", 32'(e.immB), 32'(a.immB));
        checkField(lane, "branchTag", 32'(e.branchTag), 32'(a.branchTag));
        checkField(lane, "predTaken", 32'(e.predTaken), 32'(a.predTaken));
        checkField(lane, "compressed", 32'(e.compressed), 32'(a.compressed));
    endtask

    // Looks at the lanes produced by the previous rising edge
    task automatic checkOutputs();
        fusePkg::decodedUop_t expUop;
        bit gap;
        gap = 1'b0;
        for (int l = 0; l < fusePkg::numUopsOut; l++) begin
            if (edgeKind == flushEdge) begin
                assert (!uopOut[l].valid) else failRun($sformatf(
                    "lane %0d is valid right after a reset or flush", l));
            end else if (edgeKind == holdEdge) begin
                assert (uopOut[l] === lastOut[l]) else failRun($sformatf(
                    "lane %0d changed while outEn was low", l));
            end else if (uopOut[l].valid) begin
                assert (!gap) else failRun($sformatf(
                    "lane %0d is valid above an empty lane", l));
                assert (expQ.size() > 0) else failRun($sformatf(
                    "lane %0d carries an op that was never expected", l));
                expUop = expQ.pop_front();
                compareUop(l, expUop, uopOut[l]);
            end else begin
                gap = 1'b1;
            end
            lastOut[l] = uopOut[l];
        end
    endtask

    task automatic makeUop(output fusePkg::decodedUop_t u);
        int unsigned kind;
        u = '0;
        kind = $urandom_range(0, 9);
        u.valid = $urandom_range(0, 7) != 0;
        u.pc = nextPc;
        u.compressed = $urandom_range(0, 3) == 0;
        nextPc = nextPc + (u.compressed ? 32'd2 : 32'd4);
        u.fu = fusePkg::INT;
        u.opcode = fusePkg::ADD;
        // Few registers so that neighbours often share one
        u.rd = fusePkg::regIdx_t'($urandom_range(1, 3));
        u.rs0 = u.rd;
        u.rs1 = fusePkg::regIdx_t'($urandom_range(0, 31));
        u.imm = $urandom();
        u.predTaken = $urandom_range(0, 1) != 0;
        case (kind)
            0, 1: u.opcode = ($urandom_range(0, 1) != 0) ? fusePkg::LUI : fusePkg::AUIPC;
            2, 3, 4: u.immB = 1'b1;
            5, 6: begin
                u.opcode = fusePkg::intOp_t'(int'(fusePkg::BEQ) + int'($urandom_range(0, 5)));
                u.branchTag = nextTag;
                nextTag = nextTag + 6'd1;
            end
            7: u.immB = 1'b0;
            8: begin
                u.fu = ($urandom_range(0, 1) != 0) ? fusePkg::LSU : fusePkg::MUL;
                u.opcode = fusePkg::OTHER;
            end
            default: begin
                // addi into a different register
                u.immB = 1'b1;
                u.rs0 = u.rd + 5'd8;
            end
        endcase
    endtask

    task automatic driveGroup(input bit blank);
        fusePkg::decodedUop_t u;
        for (int i = 0; i < fusePkg::numUopsIn; i++) begin
            if (blank) begin
                u = '0;
            end else begin
                makeUop(u);
            end
            uopIn[i] <= u;
        end
    endtask

    // Inputs are stable at the falling edge, so the next rising edge is known here
    task automatic sampleCycle(output bit taken);
        @(negedge clk);
        checkOutputs();
        taken = !rst && !mispredict && !full;
        if (rst || mispredict) begin
            flushModel();
            edgeKind = flushEdge;
        end else begin
            if (taken) begin
                acceptGroup(uopIn);
            end
            edgeKind = outEn ? readEdge : holdEdge;
        end
    endtask

    initial begin
        bit taken;
        bit fullSeen;
        int waitCount;
        void'($urandom(93));
        rst = 1'b1;
        mispredict = 1'b0;
        outEn = 1'b0;
        for (int i = 0; i < fusePkg::numUopsIn; i++) begin
            uopIn[i] = '0;
        end
        repeat (4) begin
            sampleCycle(taken);
            @(posedge clk);
        end
        rst <= 1'b0;

        for (int c = 0; c < 4; c++) begin
            sampleCycle(taken);
            assert (!full) else failRun("full is high with an empty buffer after reset");
            for (int l = 0; l < fusePkg::numUopsOut; l++) begin
                assert (!uopOut[l].valid) else failRun("an output lane is valid after reset");
            end
            @(posedge clk);
        end

        testName = "random";
        for (int c = 0; c < 500; c++) begin
            sampleCycle(taken);
            @(posedge clk);
            if (taken) begin
                driveGroup(1'b0);
            end
            outEn <= $urandom_range(0, 9) < 7;
            mispredict <= $urandom_range(0, 39) == 0;
        end

        testName = "stall";
        outEn <= 1'b0;
        mispredict <= 1'b0;
        fullSeen = 1'b0;
        waitCount = 0;
        while (!fullSeen && waitCount < 60) begin
            sampleCycle(taken);
            fullSeen = full;
            @(posedge clk);
            if (taken) begin
                driveGroup(1'b0);
            end
            waitCount++;
        end
        assert (fullSeen) else failRun("full did not rise while outEn was held low");
        repeat (8) begin
            sampleCycle(taken);
            @(posedge clk);
            if (taken) begin
                driveGroup(1'b0);
            end
        end

        // Empty groups push the last held ops out of the window
        testName = "drain";
        outEn <= 1'b1;
        waitCount = 0;
        do begin
            sampleCycle(taken);
            @(posedge clk);
            if (taken) begin
                driveGroup(1'b1);
            end
            waitCount++;
        end while ((expQ.size() > 0 || heldValid()) && waitCount < 200);
        assert (expQ.size() == 0 && !heldValid()) else
            failRun("timeout while waiting for the buffer to drain");
        repeat (6) begin
            sampleCycle(taken);
            @(posedge clk);
        end

        if (upperFused > 0 && branchFused > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            failRun("the random groups never formed one of the two fusable pairs");
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+dv
hdl/fusePkg.sv
hdl/queueCounter.sv
hdl/uopQueue.sv
hdl/fusionWindow.sv
hdl/fuseStage.sv
dv/fuseStageTb.sv

// ==== Makefile ====
TOP := fuseStageTb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -qF '*** PASSED ***' $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
